//--- files.f
hw/frogger_pkg.sv
hw/vga_timing.sv
hw/switch_debounce.sv
hw/palette_regs.sv
hw/frog_control.sv
hw/car_lanes.sv
hw/collision_detect.sv
hw/pixel_render.sv
hw/score_segments.sv
hw/frogger_game.sv
verif/tb_frogger.sv

//--- verif/tb_frogger.sv
module tb_frogger;
    timeunit 1ns;
    timeprecision 1ps;

    import frogger_pkg::*;

    localparam int H_VISIBLE       = 32;
    localparam int H_FRONT         = 2;
    localparam int H_SYNC          = 4;
    localparam int H_TOTAL         = 40;
    localparam int V_VISIBLE       = 24;
    localparam int V_FRONT         = 2;
    localparam int V_SYNC          = 2;
    localparam int V_TOTAL         = 30;
    localparam int TILE_SIZE       = 4;
    localparam int DEBOUNCE_LIMIT  = 3;
    localparam int MOVE_LIMIT      = 4;
    localparam int CAR_BASE_PERIOD = 8;
    localparam int HS_START        = H_VISIBLE + H_FRONT;
    localparam int VS_START        = V_VISIBLE + V_FRONT;
    localparam int FRAME_CYCLES    = H_TOTAL * V_TOTAL;
    // frog waits on the bottom row, centred.
    localparam int FROG_X0         = (H_VISIBLE / TILE_SIZE / 2) * TILE_SIZE;
    localparam int FROG_Y0         = V_VISIBLE - TILE_SIZE;
    localparam int LANE_END        = 5 * TILE_SIZE;

    logic       i_Clk;
    logic       i_rst_n;
    logic [3:0] sw;
    logic       i_write_en;
    logic       i_read_en;
    reg_addr_t  i_write_addr;
    reg_addr_t  i_read_addr;
    reg_data_t  i_write_data;
    reg_data_t  o_read_data;
    logic       o_vga_hsync;
    logic       o_vga_vsync;
    logic [2:0] o_vga_red;
    logic [2:0] o_vga_grn;
    logic [2:0] o_vga_blu;
    seg_t       o_segment;
    logic       o_game_active;

    reg_data_t  reg_model [32];
    integer     seed;
    bit         monitor_on;
    bit         colour_checks;
    int         pal_write_cycle;

    // monitor state.
    int         cycle_count = 0;
    int         frame_count = 0;
    int         score_changes = 0;
    int         exp_score = 0;
    int         tb_h = 0;
    int         tb_v = 0;
    int         h_gap = 0;
    int         h_low = 0;
    int         v_gap = 0;
    int         v_low = 0;
    bit         h_locked = 1'b0;
    bit         v_locked = 1'b0;
    logic       prev_hsync = 1'b1;
    logic       prev_vsync = 1'b1;
    seg_t       prev_segment = 7'b000_0001;
    logic [8:0] rgb_exp;
    bit         known;

    frogger_game #(
        .H_VISIBLE      (H_VISIBLE),
        .H_FRONT        (H_FRONT),
        .H_SYNC         (H_SYNC),
        .H_TOTAL        (H_TOTAL),
        .V_VISIBLE      (V_VISIBLE),
        .V_FRONT        (V_FRONT),
        .V_SYNC         (V_SYNC),
        .V_TOTAL        (V_TOTAL),
        .TILE_SIZE      (TILE_SIZE),
        .DEBOUNCE_LIMIT (DEBOUNCE_LIMIT),
        .MOVE_LIMIT     (MOVE_LIMIT),
        .CAR_BASE_PERIOD(CAR_BASE_PERIOD)
    ) dut0 (
        .i_Clk        (i_Clk),
        .i_rst_n      (i_rst_n),
        .i_switch_1   (sw[0]),
        .i_switch_2   (sw[1]),
        .i_switch_3   (sw[2]),
        .i_switch_4   (sw[3]),
        .i_write_en   (i_write_en),
        .i_read_en    (i_read_en),
        .i_write_addr (i_write_addr),
        .i_read_addr  (i_read_addr),
        .i_write_data (i_write_data),
        .o_read_data  (o_read_data),
        .o_vga_hsync  (o_vga_hsync),
        .o_vga_vsync  (o_vga_vsync),
        .o_vga_red    (o_vga_red),
        .o_vga_grn    (o_vga_grn),
        .o_vga_blu    (o_vga_blu),
        .o_segment    (o_segment),
        .o_game_active(o_game_active)
    );

    always #5 i_Clk = ~i_Clk;

    // active low, segment a in bit 6.
    function automatic seg_t segment_pattern(input int digit);
        case (digit)
            0:       return 7'b000_0001;
            1:       return 7'b100_1111;
            2:       return 7'b001_0010;
            3:       return 7'b000_0110;
            4:       return 7'b100_1100;
            5:       return 7'b010_0100;
            6:       return 7'b010_0000;
            7:       return 7'b000_1111;
            8:       return 7'b000_0000;
            9:       return 7'b000_0100;
            default: return 7'b111_1111;
        endcase
    endfunction

    function automatic logic [8:0] color_to_rgb(input reg_data_t c);
        return {c[7:5], c[4:2], c[1], c[1], c[0]};
    endfunction

    // lane rows are left out, cars move there.
    function automatic bit pixel_expected(input int h, input int v, output logic [8:0] rgb);
        rgb = '0;
        if (h >= H_VISIBLE || v >= V_VISIBLE)
            return 1'b1;
        if (h >= FROG_X0 && h < FROG_X0 + TILE_SIZE && v >= FROG_Y0)
        begin
            rgb = color_to_rgb(reg_model[PAL_FROG]);
            return 1'b1;
        end
        if (v < TILE_SIZE)
        begin
            rgb = color_to_rgb(reg_model[PAL_GOAL]);
            return 1'b1;
        end
        if (v >= LANE_END)
        begin
            rgb = color_to_rgb(reg_model[PAL_BACKGROUND]);
            return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Testbench failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timed out while waiting for %s", what);
        $display("Testbench failed");
        $fatal(1, "timeout");
    endtask

    task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
        @(negedge i_Clk);
        i_write_en   = 1'b1;
        i_write_addr = addr;
        i_write_data = data;
        reg_model[addr] = data;
        if (addr < 4)
            pal_write_cycle = cycle_count;
        @(negedge i_Clk);
        i_write_en = 1'b0;
    endtask

    task automatic read_reg(input reg_addr_t addr);
        @(negedge i_Clk);
        i_read_en   = 1'b1;
        i_read_addr = addr;
        @(negedge i_Clk);
        i_read_en = 1'b0;
        check_value($sformatf("o_read_data[%0d]", addr), o_read_data, reg_model[addr]);
    endtask

    task automatic hold_switches(input logic [3:0] value, input int cycles, input bit stay_idle);
        @(negedge i_Clk);
        sw = value;
        for (int n = 0; n < cycles; n++)
        begin
            @(negedge i_Clk);
            if (stay_idle)
                check_value("o_game_active", o_game_active, 1'b0);
        end
    endtask

    task automatic start_game();
        int waited;
        waited = 0;
        @(negedge i_Clk);
        sw = 4'b1111;
        while (!o_game_active)
        begin
            @(negedge i_Clk);
            waited++;
            if (waited > DEBOUNCE_LIMIT + 8)
                stop_on_timeout("o_game_active with all four switches held");
        end
    endtask

    task automatic wait_frames(input int count);
        int target;
        int waited;
        target = frame_count + count;
        waited = 0;
        while (frame_count < target)
        begin
            @(negedge i_Clk);
            waited++;
            if (waited > (count + 1) * FRAME_CYCLES)
                stop_on_timeout("the next vertical sync pulse");
        end
    endtask

    // outputs are sampled mid-cycle.
    always @(negedge i_Clk)
    begin
        if (monitor_on)
        begin
            cycle_count++;
            h_gap++;
            v_gap++;

            if (prev_hsync && !o_vga_hsync)
            begin
                if (h_locked)
                    check_value("o_vga_hsync period", h_gap, H_TOTAL);
                h_locked = 1'b1;
                h_gap    = 0;
                h_low    = 1;
                tb_h     = HS_START;
            end
            else
            begin
                tb_h = (tb_h + 1) % H_TOTAL;
                if (!o_vga_hsync)
                    h_low++;
                else if (!prev_hsync && h_locked)
                    check_value("o_vga_hsync low cycles", h_low, H_SYNC);
            end
            if (tb_h == 0)
                tb_v = (tb_v + 1) % V_TOTAL;

            if (prev_vsync && !o_vga_vsync)
            begin
                if (v_locked)
                    check_value("o_vga_vsync period", v_gap, FRAME_CYCLES);
                if (h_locked)
                    check_value("horizontal count at o_vga_vsync", tb_h, 0);
                v_locked = 1'b1;
                v_gap    = 0;
                v_low    = 1;
                tb_v     = VS_START;
                frame_count++;
            end
            else if (!o_vga_vsync)
                v_low++;
            else if (!prev_vsync && v_locked)
                check_value("o_vga_vsync low cycles", v_low, V_SYNC * H_TOTAL);

            // a palette write reaches the pins two edges later.
            if (colour_checks && h_locked && v_locked && cycle_count > pal_write_cycle + 3)
            begin
                known = pixel_expected(tb_h, tb_v, rgb_exp);
                if (known)
                    check_value($sformatf("o_vga_red/grn/blu at (%0d,%0d)", tb_h, tb_v),
                                {o_vga_red, o_vga_grn, o_vga_blu}, rgb_exp);
            end

            if (o_segment !== prev_segment)
            begin
                check_value("o_game_active at o_segment change", o_game_active, 1'b1);
                exp_score = (exp_score + 1) % 10;
                score_changes++;
            end
            check_value("o_segment", o_segment, segment_pattern(exp_score));

            prev_segment = o_segment;
            prev_hsync   = o_vga_hsync;
            prev_vsync   = o_vga_vsync;
        end
    end

    initial
    begin
        reg_data_t  data;
        logic [3:0] value;
        seed            = 32'hf2a5_48a1;
        i_Clk           = 1'b0;
        i_rst_n         = 1'b0;
        sw              = 4'b0000;
        i_write_en      = 1'b0;
        i_read_en       = 1'b0;
        i_write_addr    = '0;
        i_read_addr     = '0;
        i_write_data    = '0;
        monitor_on      = 1'b0;
        colour_checks   = 1'b0;
        pal_write_cycle = -100;
        for (int a = 0; a < 32; a++)
            reg_model[a] = '0;

        repeat (3) @(posedge i_Clk);
        @(negedge i_Clk);
        i_rst_n = 1'b1;
        @(posedge i_Clk);
        monitor_on    = 1'b1;
        colour_checks = 1'b1;

        @(negedge i_Clk);
        check_value("o_game_active", o_game_active, 1'b0);
        check_value("o_segment", o_segment, segment_pattern(0));

        // register file from reset, then a random fill.
        for (int a = 0; a < 32; a++)
            read_reg(reg_addr_t'(a));
        for (int a = 0; a < 32; a++)
            write_reg(reg_addr_t'(a), reg_data_t'($random(seed)));
        for (int a = 0; a < 32; a++)
            read_reg(reg_addr_t'(a));

        // address moves without a strobe.
        @(negedge i_Clk);
        i_read_addr = 5'd7;
        repeat (3)
        begin
            @(negedge i_Clk);
            check_value("o_read_data", o_read_data, reg_model[31]);
        end

        // palette changes between frames and within them.
        wait_frames(2);
        for (int f = 0; f < 4; f++)
        begin
            write_reg(PAL_GOAL, reg_data_t'($random(seed)));
            write_reg(PAL_BACKGROUND, reg_data_t'($random(seed)));
            write_reg(PAL_FROG, reg_data_t'($random(seed)));
            wait_frames(1);
        end
        for (int n = 0; n < 40; n++)
        begin
            write_reg(PAL_GOAL, reg_data_t'($random(seed)));
            repeat (37) @(negedge i_Clk);
        end
        wait_frames(1);

        // three switches never start a game.
        for (int m = 0; m < 4; m++)
        begin
            hold_switches(4'b1111 ^ (4'b0001 << m), DEBOUNCE_LIMIT + 10, 1'b1);
            hold_switches(4'b0000, DEBOUNCE_LIMIT + 10, 1'b1);
        end
        colour_checks = 1'b0;
        start_game();

        // long run, up held most of the time.
        for (int n = 0; n < 1500; n++)
        begin
            data = reg_data_t'($random(seed));
            if (data[1:0] == 2'b00)
                value = 4'b1111;
            else
                value = {data[7:5], data[2] | data[3]};
            hold_switches(value, 6 + int'(data[5:2]), 1'b0);
        end
        hold_switches(4'b0000, 20, 1'b0);
        $display("score changes seen: %0d, frames: %0d", score_changes, frame_count);

        if (score_changes == 0)
        begin
            $display("the score never changed during the random switch run");
            $display("Testbench failed");
            $fatal(1, "no crossing seen");
        end
        else
        begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

//--- hw/frogger_game.sv
module frogger_game #(
    parameter int H_VISIBLE       = 640,
    parameter int H_FRONT         = 16,
    parameter int H_SYNC          = 96,
    parameter int H_TOTAL         = 800,
    parameter int V_VISIBLE       = 480,
    parameter int V_FRONT         = 10,
    parameter int V_SYNC          = 2,
    parameter int V_TOTAL         = 525,
    parameter int TILE_SIZE       = 32,
    parameter int DEBOUNCE_LIMIT  = 250_000,
    parameter int MOVE_LIMIT      = 5_000_000,
    parameter int CAR_BASE_PERIOD = 2_000_000
) (
    input  logic                   i_Clk,
    input  logic                   i_rst_n,
    input  logic                   i_switch_1,
    input  logic                   i_switch_2,
    input  logic                   i_switch_3,
    input  logic                   i_switch_4,
    input  logic                   i_write_en,
    input  logic                   i_read_en,
    input  frogger_pkg::reg_addr_t i_write_addr,
    input  frogger_pkg::reg_addr_t i_read_addr,
    input  frogger_pkg::reg_data_t i_write_data,
    output frogger_pkg::reg_data_t o_read_data,
    output logic                   o_vga_hsync,
    output logic                   o_vga_vsync,
    output logic [2:0]             o_vga_red,
    output logic [2:0]             o_vga_grn,
    output logic [2:0]             o_vga_blu,
    output frogger_pkg::seg_t      o_segment,
    output logic                   o_game_active
);
    import frogger_pkg::*;

    game_state_e state;

    logic [3:0] sw_raw;
    logic [3:0] sw_db;
    hpos_t      h_count;
    vcnt_t      v_count;
    logic       hsync;
    logic       vsync;
    color_t     col_background;
    color_t     col_goal;
    color_t     col_frog;
    color_t     col_car;
    hpos_t      frog_x;
    vpos_t      frog_y;
    score_t     score;
    logic       crossed;
    logic       collided;
    hpos_t      car_x_0;
    hpos_t      car_x_1;
    hpos_t      car_x_2;
    hpos_t      car_x_3;

    assign sw_raw = {i_switch_4, i_switch_3, i_switch_2, i_switch_1};

    vga_timing #(
        .H_VISIBLE(H_VISIBLE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_TOTAL  (H_TOTAL),
        .V_VISIBLE(V_VISIBLE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_TOTAL  (V_TOTAL)
    ) u_vga_timing (
        .i_Clk    (i_Clk),
        .i_rst_n  (i_rst_n),
        .o_h_count(h_count),
        .o_v_count(v_count),
        .o_hsync  (hsync),
        .o_vsync  (vsync)
    );

    // switch 1 up, 2 left, 3 right, 4 down.
    for (genvar i = 0; i < 4; i++)
    begin : g_debounce
        switch_debounce #(
            .DEBOUNCE_LIMIT(DEBOUNCE_LIMIT)
        ) u_switch_debounce (
            .i_Clk   (i_Clk),
            .i_rst_n (i_rst_n),
            .i_switch(sw_raw[i]),
            .o_switch(sw_db[i])
        );
    end

    palette_regs u_palette_regs (
        .i_Clk       (i_Clk),
        .i_rst_n     (i_rst_n),
        .i_write_en  (i_write_en),
        .i_write_addr(i_write_addr),
        .i_write_data(i_write_data),
        .i_read_en   (i_read_en),
        .i_read_addr (i_read_addr),
        .o_read_data (o_read_data),
        .o_background(col_background),
        .o_goal      (col_goal),
        .o_frog      (col_frog),
        .o_car       (col_car)
    );

    frog_control #(
        .H_VISIBLE (H_VISIBLE),
        .V_VISIBLE (V_VISIBLE),
        .TILE_SIZE (TILE_SIZE),
        .MOVE_LIMIT(MOVE_LIMIT)
    ) u_frog_control (
        .i_Clk        (i_Clk),
        .i_rst_n      (i_rst_n),
        .i_game_active(o_game_active),
        .i_collided   (collided),
        .i_up         (sw_db[0]),
        .i_left       (sw_db[1]),
        .i_right      (sw_db[2]),
        .i_down       (sw_db[3]),
        .o_frog_x     (frog_x),
        .o_frog_y     (frog_y),
        .o_score      (score),
        .o_crossed    (crossed)
    );

    car_lanes #(
        .H_VISIBLE      (H_VISIBLE),
        .TILE_SIZE      (TILE_SIZE),
        .CAR_BASE_PERIOD(CAR_BASE_PERIOD)
    ) u_car_lanes (
        .i_Clk        (i_Clk),
        .i_rst_n      (i_rst_n),
        .i_game_active(o_game_active),
        .i_score      (score),
        .i_crossed    (crossed),
        .o_car_x_0    (car_x_0),
        .o_car_x_1    (car_x_1),
        .o_car_x_2    (car_x_2),
        .o_car_x_3    (car_x_3)
    );

    collision_detect #(
        .TILE_SIZE(TILE_SIZE)
    ) u_collision_detect (
        .i_Clk        (i_Clk),
        .i_rst_n      (i_rst_n),
        .i_game_active(o_game_active),
        .i_frog_x     (frog_x),
        .i_frog_y     (frog_y),
        .i_car_x_0    (car_x_0),
        .i_car_x_1    (car_x_1),
        .i_car_x_2    (car_x_2),
        .i_car_x_3    (car_x_3),
        .o_collided   (collided)
    );

    pixel_render #(
        .H_VISIBLE(H_VISIBLE),
        .V_VISIBLE(V_VISIBLE),
        .TILE_SIZE(TILE_SIZE)
    ) u_pixel_render (
        .i_Clk       (i_Clk),
        .i_rst_n     (i_rst_n),
        .i_h_count   (h_count),
        .i_v_count   (v_count),
        .i_hsync     (hsync),
        .i_vsync     (vsync),
        .i_background(col_background),
        .i_goal      (col_goal),
        .i_frog      (col_frog),
        .i_car       (col_car),
        .i_frog_x    (frog_x),
        .i_frog_y    (frog_y),
        .i_car_x_0   (car_x_0),
        .i_car_x_1   (car_x_1),
        .i_car_x_2   (car_x_2),
        .i_car_x_3   (car_x_3),
        .o_hsync     (o_vga_hsync),
        .o_vsync     (o_vga_vsync),
        .o_red       (o_vga_red),
        .o_grn       (o_vga_grn),
        .o_blu       (o_vga_blu)
    );

    score_segments u_score_segments (
        .i_Clk    (i_Clk),
        .i_rst_n  (i_rst_n),
        .i_score  (score),
        .o_segment(o_segment)
    );

    // all four switches start a game.
    always_ff @(posedge i_Clk)
    begin
        if (!i_rst_n)
        begin
            state <= IDLE;
        end
        else
        begin
            case (state)
                IDLE:    if (&sw_db) state <= RUNNING;
                RUNNING: if (collided) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    assign o_game_active = (state == RUNNING);

endmodule

//--- hw/score_segments.sv
module score_segments (
    input  logic                i_Clk,
    input  logic                i_rst_n,
    input  frogger_pkg::score_t i_score,
    output frogger_pkg::seg_t   o_segment
);
    import frogger_pkg::*;

    always_ff @(posedge i_Clk)
    begin
        if (!i_rst_n)
            o_segment <= SEG_TABLE[0];
        else if (i_score <= 4'd9)
            o_segment <= SEG_TABLE[i_score];
        else
            o_segment <= SEG_OFF;
    end

endmodule

//--- hw/pixel_render.sv
module pixel_render #(
    parameter int H_VISIBLE = 640,
    parameter int V_VISIBLE = 480,
    parameter int TILE_SIZE = 32
) (
    input  logic                i_Clk,
    input  logic                i_rst_n,
    input  frogger_pkg::hpos_t  i_h_count,
    input  frogger_pkg::vcnt_t  i_v_count,
    input  logic                i_hsync,
    input  logic                i_vsync,
    input  frogger_pkg::color_t i_background,
    input  frogger_pkg::color_t i_goal,
    input  frogger_pkg::color_t i_frog,
    input  frogger_pkg::color_t i_car,
    input  frogger_pkg::hpos_t  i_frog_x,
    input  frogger_pkg::vpos_t  i_frog_y,
    input  frogger_pkg::hpos_t  i_car_x_0,
    input  frogger_pkg::hpos_t  i_car_x_1,
    input  frogger_pkg::hpos_t  i_car_x_2,
    input  frogger_pkg::hpos_t  i_car_x_3,
    output logic                o_hsync,
    output logic                o_vsync,
    output logic [2:0]          o_red,
    output logic [2:0]          o_grn,
    output logic [2:0]          o_blu
);
    import frogger_pkg::*;

    localparam hpos_t TILE_X = hpos_t'(TILE_SIZE);
    localparam vpos_t TILE_Y = vpos_t'(TILE_SIZE);

    hpos_t  car_x [4];
    color_t pix;
    logic   frog_hit;
    logic   car_hit;

    assign car_x = '{i_car_x_0, i_car_x_1, i_car_x_2, i_car_x_3};

    always_comb
    begin
        frog_hit = (i_h_count >= i_frog_x) && (i_h_count < i_frog_x + TILE_X) &&
                   (i_v_count >= i_frog_y) && (i_v_count < i_frog_y + TILE_Y);
        car_hit = 1'b0;
        for (int i = 0; i < 4; i++)
            if ((i_v_count >= (i + 1) * TILE_SIZE) && (i_v_count < (i + 2) * TILE_SIZE) &&
                (i_h_count >= car_x[i]) && (i_h_count < car_x[i] + TILE_X))
                car_hit = 1'b1;

        if ((i_h_count >= H_VISIBLE) || (i_v_count >= V_VISIBLE))
            pix = '0;
        else if (frog_hit)
            pix = i_frog;
        else if (car_hit)
            pix = i_car;
        else if (i_v_count < TILE_SIZE)
            pix = i_goal;
        else
            pix = i_background;
    end

    // syncs delayed to line up with the colour register.
    always_ff @(posedge i_Clk)
    begin
        if (!i_rst_n)
        begin
            o_hsync <= 1'b1;
            o_vsync <= 1'b1;
            o_red   <= '0;
            o_grn   <= '0;
            o_blu   <= '0;
        end
        else
        begin
            o_hsync <= i_hsync;
            o_vsync <= i_vsync;
            o_red   <= pix[7:5];
            o_grn   <= pix[4:2];
            o_blu   <= {pix[1], pix[1], pix[0]};
        end
    end

endmodule

//--- hw/collision_detect.sv
module collision_detect #(
    parameter int TILE_SIZE = 32
) (
    input  logic               i_Clk,
    input  logic               i_rst_n,
    input  logic               i_game_active,
    input  frogger_pkg::hpos_t i_frog_x,
    input  frogger_pkg::vpos_t i_frog_y,
    input  frogger_pkg::hpos_t i_car_x_0,
    input  frogger_pkg::hpos_t i_car_x_1,
    input  frogger_pkg::hpos_t i_car_x_2,
    input  frogger_pkg::hpos_t i_car_x_3,
    output logic               o_collided
);
    import frogger_pkg::*;

    localparam hpos_t TILE_X = hpos_t'(TILE_SIZE);

    hpos_t      car_x [4];
    logic [3:0] hit;

    assign car_x = '{i_car_x_0, i_car_x_1, i_car_x_2, i_car_x_3};

    // lane i sits on tile row i+1.
    always_comb
    begin
        for (int i = 0; i < 4; i++)
            hit[i] = (i_frog_y == vpos_t'((i + 1) * TILE_SIZE)) &&
                     (i_frog_x < car_x[i] + TILE_X) && (car_x[i] < i_frog_x + TILE_X);
    end

    always_ff @(posedge i_Clk)
    begin
        if (!i_rst_n)
            o_collided <= 1'b0;
        else
            o_collided <= i_game_active && (|hit) && !o_collided;
    end

endmodule

//--- hw/car_lanes.sv
module car_lanes #(
    parameter int H_VISIBLE       = 640,
    parameter int TILE_SIZE       = 32,
    parameter int CAR_BASE_PERIOD = 2_000_000
) (
    input  logic                i_Clk,
    input  logic                i_rst_n,
    input  logic                i_game_active,
    input  frogger_pkg::score_t i_score,
    input  logic                i_crossed,
    output frogger_pkg::hpos_t  o_car_x_0,
    output frogger_pkg::hpos_t  o_car_x_1,
    output frogger_pkg::hpos_t  o_car_x_2,
    output frogger_pkg::hpos_t  o_car_x_3
);
    import frogger_pkg::*;

    localparam int    CNT_W = $clog2(CAR_BASE_PERIOD + 1);
    localparam hpos_t X_MAX = hpos_t'(H_VISIBLE - 1);

    logic [CNT_W-1:0] step_cnt;
    logic [CNT_W-1:0] step_limit;
    logic             step;
    logic [3:0]       lfsr;
    // set bit moves right.
    logic [3:0]       dir;
    hpos_t            car_x [4];

    // two points of score halve the period.
    always_comb
    begin
        step_limit = CNT_W'(CAR_BASE_PERIOD) >> (i_score >> 1);
        if (step_limit == '0)
            step_limit = CNT_W'(1);
    end

    assign step = i_game_active && (step_cnt >= step_limit - 1'b1);

    always_ff @(posedge i_Clk)
    begin
        if (!i_rst_n)
        begin
            step_cnt <= '0;
            lfsr     <= 4'b1001;
            dir      <= 4'b0101;
            for (int i = 0; i < 4; i++)
                car_x[i] <= hpos_t'((i * 2 * TILE_SIZE) % H_VISIBLE);
        end
        else
        begin
            // x^4 + x^3 + 1.
            lfsr <= {lfsr[2:0], lfsr[3] ^ lfsr[2]};
            if (i_crossed)
                dir <= dir ^ lfsr;
            if (!i_game_active || step)
                step_cnt <= '0;
            else
                step_cnt <= step_cnt + 1'b1;
            if (step)
            begin
                for (int i = 0; i < 4; i++)
                begin
                    if (dir[i])
                        car_x[i] <= (car_x[i] == X_MAX) ? '0 : car_x[i] + 1'b1;
                    else
                        car_x[i] <= (car_x[i] == '0) ? X_MAX : car_x[i] - 1'b1;
                end
            end
        end
    end

    assign o_car_x_0 = car_x[0];
    assign o_car_x_1 = car_x[1];
    assign o_car_x_2 = car_x[2];
    assign o_car_x_3 = car_x[3];

endmodule

//--- hw/frog_control.sv
module frog_control #(
    parameter int H_VISIBLE  = 640,
    parameter int V_VISIBLE  = 480,
    parameter int TILE_SIZE  = 32,
    parameter int MOVE_LIMIT = 5_000_000
) (
    input  logic                i_Clk,
    input  logic                i_rst_n,
    input  logic                i_game_active,
    input  logic                i_collided,
    input  logic                i_up,
    input  logic                i_left,
    input  logic                i_right,
    input  logic                i_down,
    output frogger_pkg::hpos_t  o_frog_x,
    output frogger_pkg::vpos_t  o_frog_y,
    output frogger_pkg::score_t o_score,
    output logic                o_crossed
);
    import frogger_pkg::*;

    localparam int    CNT_W   = $clog2(MOVE_LIMIT + 1);
    localparam hpos_t TILE_X  = hpos_t'(TILE_SIZE);
    localparam vpos_t TILE_Y  = vpos_t'(TILE_SIZE);
    localparam hpos_t START_X = hpos_t'((H_VISIBLE / TILE_SIZE / 2) * TILE_SIZE);
    localparam vpos_t START_Y = vpos_t'(V_VISIBLE - TILE_SIZE);
    localparam hpos_t RIGHT_X = hpos_t'(H_VISIBLE - TILE_SIZE);

    logic [CNT_W-1:0] move_cnt;
    logic             any_dir;
    logic             move_tick;

    assign any_dir   = i_up | i_left | i_right | i_down;
    assign move_tick = i_game_active && any_dir && (move_cnt == CNT_W'(MOVE_LIMIT - 1));

    always_ff @(posedge i_Clk)
    begin
        if (!i_rst_n)
        begin
            move_cnt  <= '0;
            o_frog_x  <= START_X;
            o_frog_y  <= START_Y;
            o_score   <= '0;
            o_crossed <= 1'b0;
        end
        else
        begin
            o_crossed <= 1'b0;
            if (!i_game_active || !any_dir || move_tick)
                move_cnt <= '0;
            else
                move_cnt <= move_cnt + 1'b1;

            if (i_collided)
            begin
                o_frog_x <= START_X;
                o_frog_y <= START_Y;
            end
            else if (i_game_active && o_frog_y == '0)
            begin
                // made it across.
                o_crossed <= 1'b1;
                o_score   <= (o_score == 4'd9) ? '0 : o_score + 1'b1;
                o_frog_x  <= START_X;
                o_frog_y  <= START_Y;
            end
            else if (move_tick)
            begin
                if (i_up && o_frog_y >= TILE_Y)
                    o_frog_y <= o_frog_y - TILE_Y;
                else if (i_down && o_frog_y < START_Y)
                    o_frog_y <= o_frog_y + TILE_Y;
                else if (i_left && o_frog_x >= TILE_X)
                    o_frog_x <= o_frog_x - TILE_X;
                else if (i_right && o_frog_x < RIGHT_X)
                    o_frog_x <= o_frog_x + TILE_X;
            end
        end
    end

endmodule

//--- hw/palette_regs.sv
module palette_regs (
    input  logic                   i_Clk,
    input  logic                   i_rst_n,
    input  logic                   i_write_en,
    input  frogger_pkg::reg_addr_t i_write_addr,
    input  frogger_pkg::reg_data_t i_write_data,
    input  logic                   i_read_en,
    input  frogger_pkg::reg_addr_t i_read_addr,
    output frogger_pkg::reg_data_t o_read_data,
    output frogger_pkg::color_t    o_background,
    output frogger_pkg::color_t    o_goal,
    output frogger_pkg::color_t    o_frog,
    output frogger_pkg::color_t    o_car
);
    import frogger_pkg::*;

    reg_data_t regs [32];

    always_ff @(posedge i_Clk)
    begin
        if (!i_rst_n)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
            o_read_data <= '0;
        end
        else
        begin
            if (i_write_en)
                regs[i_write_addr] <= i_write_data;
            // read returns the old byte on a same-cycle write.
            if (i_read_en)
                o_read_data <= regs[i_read_addr];
        end
    end

    assign o_background = regs[PAL_BACKGROUND];
    assign o_goal       = regs[PAL_GOAL];
    assign o_frog       = regs[PAL_FROG];
    assign o_car        = regs[PAL_CAR];

endmodule

//--- hw/switch_debounce.sv
module switch_debounce #(
    parameter int DEBOUNCE_LIMIT = 250_000
) (
    input  logic i_Clk,
    input  logic i_rst_n,
    input  logic i_switch,
    output logic o_switch
);
    localparam int CNT_W = $clog2(DEBOUNCE_LIMIT + 1);

    logic [CNT_W-1:0] stable_cnt;

    always_ff @(posedge i_Clk)
    begin
        if (!i_rst_n)
        begin
            stable_cnt <= '0;
            o_switch   <= 1'b0;
        end
        else if (i_switch != o_switch)
        begin
            if (stable_cnt == CNT_W'(DEBOUNCE_LIMIT))
            begin
                o_switch   <= i_switch;
                stable_cnt <= '0;
            end
            else
                stable_cnt <= stable_cnt + 1'b1;
        end
        else
            stable_cnt <= '0;
    end

endmodule

//--- hw/vga_timing.sv
module vga_timing #(
    parameter int H_VISIBLE = 640,
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_TOTAL   = 800,
    parameter int V_VISIBLE = 480,
    parameter int V_FRONT   = 10,
    parameter int V_SYNC    = 2,
    parameter int V_TOTAL   = 525
) (
    input  logic               i_Clk,
    input  logic               i_rst_n,
    output frogger_pkg::hpos_t o_h_count,
    output frogger_pkg::vcnt_t o_v_count,
    output logic               o_hsync,
    output logic               o_vsync
);
    import frogger_pkg::*;

    localparam int HS_START = H_VISIBLE + H_FRONT;
    localparam int VS_START = V_VISIBLE + V_FRONT;

    always_ff @(posedge i_Clk)
    begin
        if (!i_rst_n)
        begin
            o_h_count <= '0;
            o_v_count <= '0;
        end
        else if (o_h_count == hpos_t'(H_TOTAL - 1))
        begin
            o_h_count <= '0;
            if (o_v_count == vcnt_t'(V_TOTAL - 1))
                o_v_count <= '0;
            else
                o_v_count <= o_v_count + 1'b1;
        end
        else
        begin
            o_h_count <= o_h_count + 1'b1;
        end
    end

    // negative sync pulses.
    assign o_hsync = !((o_h_count >= HS_START) && (o_h_count < HS_START + H_SYNC));
    assign o_vsync = !((o_v_count >= VS_START) && (o_v_count < VS_START + V_SYNC));

endmodule

//--- hw/frogger_pkg.sv
package frogger_pkg;

    typedef logic [9:0] hpos_t;
    typedef logic [8:0] vpos_t;
    // one bit wider than vpos_t, the frame runs past 511 lines.
    typedef logic [$bits(vpos_t):0] vcnt_t;
    typedef logic [3:0] score_t;
    typedef logic [4:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;
    // rrr_ggg_bb.
    typedef logic [7:0] color_t;
    // active low, bit 6 is segment a, bit 0 is segment g.
    typedef logic [6:0] seg_t;

    typedef enum logic {
        IDLE,
        RUNNING
    } game_state_e;

    localparam reg_addr_t PAL_BACKGROUND = 5'd0;
    localparam reg_addr_t PAL_GOAL = 5'd1;
    localparam reg_addr_t PAL_FROG = 5'd2;
    localparam reg_addr_t PAL_CAR = 5'd3;

    localparam seg_t SEG_OFF = 7'b111_1111;

    localparam seg_t SEG_TABLE [10] = '{
        7'b000_0001, 7'b100_1111, 7'b001_0010, 7'b000_0110, 7'b100_1100,
        7'b010_0100, 7'b010_0000, 7'b000_1111, 7'b000_0000, 7'b000_0100
    };

endpackage
